/* ball_link.f */
source/ball_link_pkg.sv
source/i2c_bus_pkg.sv
source/ball_frame_capture.sv
source/i2c_write_sequencer.sv
source/i2c_byte_engine.sv
source/ball_link_top.sv
bench/i2c_slave_model.sv
bench/ball_link_tb.sv

/* bench/ball_link_tb.sv */
`timescale 1ns/1ps

module ball_link_tb;

    localparam logic [6:0] slave_addr = 7'h55;
    localparam int         clk_div    = 4;
    // a byte with its ack bit is the longest engine operation
    localparam int byte_cycles    = 9 * 4 * clk_div;
    localparam int timeout_cycles = 13 * 8 * byte_cycles;

    logic                          clk;
    logic                          reset;
    logic                          ball_send_trigger;
    ball_link_pkg::ball_snapshot_t ball;
    logic                          ball_moving_left;
    logic                          nack_address;
    logic                          scl_oe;
    logic                          sda_oe;
    logic                          scl;
    logic                          sda;
    logic                          busy;
    logic                          nack;
    logic [7:0]                    phase_led;
    logic                          start_seen;
    logic                          stop_seen;
    logic                          byte_seen;
    logic [7:0]                    byte_data;

    logic [7:0]                    expected_q[$];
    logic [7:0]                    exp_byte;
    logic [31:0]                   lcg_state;
    ball_link_pkg::ball_snapshot_t snap_a;
    ball_link_pkg::ball_snapshot_t snap_b;
    int errors      = 0;
    int start_count = 0;
    int stop_count  = 0;
    int bytes_total = 0;
    int cycles      = 0;
    int transfers   = 0;
    int seen_before = 0;

    ball_link_top #(
        .slave_addr (slave_addr),
        .clk_div    (clk_div)
    ) u_dut (
        .clk               (clk),
        .reset             (reset),
        .ball_send_trigger (ball_send_trigger),
        .ball              (ball),
        .ball_moving_left  (ball_moving_left),
        .sda_in            (sda),
        .scl_in            (scl),
        .scl_oe            (scl_oe),
        .sda_oe            (sda_oe),
        .busy              (busy),
        .nack              (nack),
        .phase_led         (phase_led)
    );

    i2c_slave_model u_slave (
        .clk          (clk),
        .scl_oe       (scl_oe),
        .sda_oe       (sda_oe),
        .nack_address (nack_address),
        .scl          (scl),
        .sda          (sda),
        .start_seen   (start_seen),
        .stop_seen    (stop_seen),
        .byte_seen    (byte_seen),
        .byte_data    (byte_data)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // address byte with write bit, then the four frame bytes
    function automatic logic [39:0] expected_bytes(ball_link_pkg::ball_snapshot_t s);
        logic [7:0] addr_byte;
        addr_byte = {slave_addr, 1'b0};
        return {addr_byte, s.y[9:8], 6'd0, s.y[7:0], s.vy, 8'h01};
    endfunction

    task automatic random_snapshot(output ball_link_pkg::ball_snapshot_t s);
        lcg_state = lcg_next(lcg_state);
        s.y  = lcg_state[31:22];
        s.vy = lcg_state[15:8];
    endtask

    task automatic queue_expected(input ball_link_pkg::ball_snapshot_t s, input int count);
        logic [39:0] seq;
        seq = expected_bytes(s);
        for (int i = 0; i < count; i++) begin
            expected_q.push_back(seq[39 - 8 * i -: 8]);
        end
    endtask

    task automatic pulse_trigger(input ball_link_pkg::ball_snapshot_t s);
        @(negedge clk);
        ball              = s;
        ball_send_trigger = 1'b1;
        @(negedge clk);
        ball_send_trigger = 1'b0;
    endtask

    task automatic wait_until_idle;
        while (!busy) begin
            @(negedge clk);
        end
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] want);
        if (got !== want) begin
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic check_transfers(input int count);
        if (start_count != count || stop_count != count) begin
            $display("bus showed %0d starts and %0d stops where %0d of each were due",
                     start_count, stop_count, count);
            errors++;
        end
    endtask

    // slave pulses change on the falling edge, stable here
    always @(posedge clk) begin
        if (start_seen) begin
            start_count++;
        end
        if (byte_seen) begin
            bytes_total++;
            if (expected_q.size() == 0) begin
                $display("unexpected byte %02h on the bus at %0t", byte_data, $time);
                errors++;
            end else begin
                exp_byte = expected_q.pop_front();
                if (byte_data !== exp_byte) begin
                    $display("** Error at %0t: byte_data expected %02h got %02h",
                             $time, exp_byte, byte_data);
                    errors++;
                end
            end
        end
        if (stop_seen) begin
            stop_count++;
            if (expected_q.size() != 0) begin
                $display("stop at %0t with %0d expected bytes never sent",
                         $time, expected_q.size());
                errors++;
                expected_q.delete();
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && $countones(phase_led) != 1) begin
            $display("** Error at %0t: phase_led expected one-hot got %08b", $time, phase_led);
            errors++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        reset             = 1'b1;
        ball_send_trigger = 1'b0;
        ball              = '0;
        ball_moving_left  = 1'b0;
        nack_address      = 1'b0;
        lcg_state         = 32'h737e_c85b;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        check_value("scl_oe", {7'd0, scl_oe}, 8'h00);
        check_value("sda_oe", {7'd0, sda_oe}, 8'h00);
        check_value("busy", {7'd0, busy}, 8'h00);
        check_value("nack", {7'd0, nack}, 8'h00);
        check_value("phase_led", phase_led, 8'h01);

        for (int i = 0; i < 8; i++) begin
            random_snapshot(snap_a);
            queue_expected(snap_a, 5);
            pulse_trigger(snap_a);
            wait_until_idle();
            transfers++;
            check_transfers(transfers);
            repeat (4) @(negedge clk);
        end

        // second trigger lands while the first frame is on the wire
        random_snapshot(snap_a);
        snap_b = ~snap_a;
        queue_expected(snap_a, 5);
        pulse_trigger(snap_a);
        repeat (20) @(negedge clk);
        pulse_trigger(snap_b);
        wait_until_idle();
        repeat (60) @(negedge clk);
        transfers++;
        check_transfers(transfers);
        check_value("busy", {7'd0, busy}, 8'h00);

        // cancel once the second data byte has been clocked out
        random_snapshot(snap_a);
        queue_expected(snap_a, 3);
        seen_before = bytes_total;
        pulse_trigger(snap_a);
        while (bytes_total < seen_before + 3) begin
            @(negedge clk);
        end
        // single cycle, the sequencer has to remember it until the byte ends
        ball_moving_left = 1'b1;
        @(negedge clk);
        ball_moving_left = 1'b0;
        wait_until_idle();
        transfers++;
        check_transfers(transfers);
        repeat (4) @(negedge clk);

        nack_address = 1'b1;
        random_snapshot(snap_a);
        queue_expected(snap_a, 1);
        pulse_trigger(snap_a);
        wait_until_idle();
        nack_address = 1'b0;
        transfers++;
        check_transfers(transfers);
        check_value("nack", {7'd0, nack}, 8'h01);

        random_snapshot(snap_a);
        queue_expected(snap_a, 5);
        pulse_trigger(snap_a);
        @(negedge clk);
        check_value("nack", {7'd0, nack}, 8'h00);
        wait_until_idle();
        transfers++;
        check_transfers(transfers);
        check_value("nack", {7'd0, nack}, 8'h00);

        $display("run complete: %0d errors, %0d bytes compared", errors, bytes_total);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* bench/i2c_slave_model.sv */
`timescale 1ns/1ps

module i2c_slave_model (
    input  logic       clk,
    input  logic       scl_oe,
    input  logic       sda_oe,
    input  logic       nack_address,
    output logic       scl,
    output logic       sda,
    output logic       start_seen,
    output logic       stop_seen,
    output logic       byte_seen,
    output logic [7:0] byte_data
);

    logic       sda_pull;
    logic       prev_scl;
    logic       prev_sda;
    logic       active;
    logic       ack_phase;
    logic [3:0] bit_cnt;
    logic [7:0] shift;
    int         byte_idx;

    // open drain, either side pulls low
    assign scl = !scl_oe;
    assign sda = !(sda_oe || sda_pull);

    initial begin
        sda_pull   = 1'b0;
        prev_scl   = 1'b1;
        prev_sda   = 1'b1;
        active     = 1'b0;
        ack_phase  = 1'b0;
        bit_cnt    = 4'd0;
        shift      = 8'h00;
        byte_idx   = 0;
        start_seen = 1'b0;
        stop_seen  = 1'b0;
        byte_seen  = 1'b0;
        byte_data  = 8'h00;
    end

    // lines only move on rising clk, so the falling edge sees them settled
    always @(negedge clk) begin
        start_seen <= 1'b0;
        stop_seen  <= 1'b0;
        byte_seen  <= 1'b0;
        if (scl && prev_scl && prev_sda && !sda) begin
            start_seen <= 1'b1;
            active     <= 1'b1;
            ack_phase  <= 1'b0;
            bit_cnt    <= 4'd0;
            byte_idx   <= 0;
        end else if (scl && prev_scl && !prev_sda && sda) begin
            stop_seen <= 1'b1;
            active    <= 1'b0;
        end else if (active && scl && !prev_scl && bit_cnt < 4'd8) begin
            shift   <= {shift[6:0], sda};
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd7) begin
                byte_seen <= 1'b1;
                byte_data <= {shift[6:0], sda};
            end
        end else if (active && !scl && prev_scl && bit_cnt == 4'd8) begin
            if (!ack_phase) begin
                // first byte after start is the address
                ack_phase <= 1'b1;
                sda_pull  <= !(nack_address && byte_idx == 0);
            end else begin
                ack_phase <= 1'b0;
                sda_pull  <= 1'b0;
                bit_cnt   <= 4'd0;
                byte_idx  <= byte_idx + 1;
            end
        end
        prev_scl <= scl;
        prev_sda <= sda;
    end

endmodule

/* source/ball_link_top.sv */
`timescale 1ns/1ps

module ball_link_top #(
    parameter logic [6:0] slave_addr = 7'h55,
    parameter int         clk_div    = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ball_send_trigger,
    input  ball_link_pkg::ball_snapshot_t ball,
    input  logic                          ball_moving_left,
    input  logic                          sda_in,
    // left unread since the engine has no clock stretching
    input  logic                          scl_in,
    output logic                          scl_oe,
    output logic                          sda_oe,
    output logic                          busy,
    output logic                          nack,
    output logic [7:0]                    phase_led
);

    ball_link_pkg::ball_frame_t frame;
    logic                       frame_valid;
    logic                       frame_taken;
    i2c_bus_pkg::i2c_cmd_t      cmd;
    logic                       cmd_valid;
    i2c_bus_pkg::i2c_status_t   status;

    ball_frame_capture u_capture (
        .clk               (clk),
        .reset             (reset),
        .ball_send_trigger (ball_send_trigger),
        .ball              (ball),
        .busy              (busy),
        .frame_taken       (frame_taken),
        .frame             (frame),
        .frame_valid       (frame_valid)
    );

    i2c_write_sequencer #(
        .slave_addr (slave_addr)
    ) u_sequencer (
        .clk              (clk),
        .reset            (reset),
        .frame            (frame),
        .frame_valid      (frame_valid),
        .ball_moving_left (ball_moving_left),
        .status           (status),
        .frame_taken      (frame_taken),
        .cmd              (cmd),
        .cmd_valid        (cmd_valid),
        .busy             (busy),
        .nack             (nack),
        .phase_led        (phase_led)
    );

    i2c_byte_engine #(
        .clk_div (clk_div)
    ) u_engine (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .sda_in    (sda_in),
        .status    (status),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe)
    );

endmodule

/* source/i2c_byte_engine.sv */
`timescale 1ns/1ps

module i2c_byte_engine #(
    parameter int clk_div = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  i2c_bus_pkg::i2c_cmd_t    cmd,
    input  logic                     cmd_valid,
    input  logic                     sda_in,
    output i2c_bus_pkg::i2c_status_t status,
    output logic                     scl_oe,
    output logic                     sda_oe
);

    localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;
    localparam logic [div_w-1:0] div_last = div_w'(clk_div - 1);

    typedef enum logic [1:0] {
        eng_idle,
        eng_start,
        eng_byte,
        eng_stop
    } eng_state_t;

    eng_state_t       state;
    eng_state_t       op_state;
    logic [div_w-1:0] div_cnt;
    logic [1:0]       quarter;
    logic [3:0]       bit_cnt;
    logic [7:0]       tx_byte;
    logic             accept;
    logic             tick;
    logic             done_q;
    logic             ack_q;

    // bit 8 is the ack slot, left released for the slave
    function automatic logic bit_level(logic [7:0] b, logic [3:0] idx);
        if (idx > 4'd7) begin
            return 1'b1;
        end
        return b[3'd7 - idx[2:0]];
    endfunction

    // {scl_oe, sda_oe} for one quarter of an operation
    function automatic logic [1:0] quarter_lines(eng_state_t s, logic [1:0] q, logic level);
        logic [1:0] l;
        case (s)
            eng_start: l = (q == 2'd0) ? 2'b00 : (q == 2'd3) ? 2'b11 : 2'b01;
            // scl high in quarters 1 and 2, sda set up while low
            eng_byte:  l = {(q == 2'd0 || q == 2'd3), ~level};
            eng_stop:  l = (q == 2'd0) ? 2'b11 : (q == 2'd1) ? 2'b01 : 2'b00;
            default:   l = 2'b00;
        endcase
        return l;
    endfunction

    always_comb begin
        case (cmd.op)
            i2c_bus_pkg::op_start: op_state = eng_start;
            i2c_bus_pkg::op_byte:  op_state = eng_byte;
            default:               op_state = eng_stop;
        endcase
    end

    assign accept       = (state == eng_idle) && cmd_valid;
    assign tick         = (div_cnt == div_last);
    assign status.ready = (state == eng_idle);
    assign status.done  = done_q;
    assign status.ack   = ack_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= eng_idle;
            div_cnt <= '0;
            quarter <= 2'd0;
            bit_cnt <= 4'd0;
            done_q  <= 1'b0;
            ack_q   <= 1'b0;
            scl_oe  <= 1'b0;
            sda_oe  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                state              <= op_state;
                div_cnt            <= '0;
                quarter            <= 2'd0;
                bit_cnt            <= 4'd0;
                {scl_oe, sda_oe}   <= quarter_lines(op_state, 2'd0, cmd.data[7]);
            end else if (state != eng_idle) begin
                if (tick) begin
                    div_cnt <= '0;
                    quarter <= quarter + 2'd1;
                    if (quarter != 2'd3) begin
                        {scl_oe, sda_oe} <= quarter_lines(state, quarter + 2'd1,
                                                          bit_level(tx_byte, bit_cnt));
                    end else if (state == eng_byte && bit_cnt != 4'd8) begin
                        bit_cnt          <= bit_cnt + 4'd1;
                        {scl_oe, sda_oe} <= quarter_lines(state, 2'd0,
                                                          bit_level(tx_byte, bit_cnt + 4'd1));
                    end else begin
                        // lines keep their last level until the next command
                        state  <= eng_idle;
                        done_q <= 1'b1;
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
            // middle of the ninth scl high
            if (tick && state == eng_byte && quarter == 2'd1 && bit_cnt == 4'd8) begin
                ack_q <= ~sda_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tx_byte <= cmd.data;
        end
    end

    sda_moves_with_scl_low: assert property (@(posedge clk) disable iff (reset)
        (state == eng_byte) && $changed(sda_oe) |-> scl_oe && $past(scl_oe));

endmodule

/* source/i2c_write_sequencer.sv */
`timescale 1ns/1ps

module i2c_write_sequencer #(
    parameter logic [6:0] slave_addr = 7'h55
) (
    input  logic                       clk,
    input  logic                       reset,
    input  ball_link_pkg::ball_frame_t frame,
    input  logic                       frame_valid,
    input  logic                       ball_moving_left,
    input  i2c_bus_pkg::i2c_status_t   status,
    output logic                       frame_taken,
    output i2c_bus_pkg::i2c_cmd_t      cmd,
    output logic                       cmd_valid,
    output logic                       busy,
    output logic                       nack,
    output logic [7:0]                 phase_led
);

    localparam i2c_bus_pkg::i2c_cmd_t cmd_start =
        '{op: i2c_bus_pkg::op_start, data: 8'h00};
    localparam i2c_bus_pkg::i2c_cmd_t cmd_stop =
        '{op: i2c_bus_pkg::op_stop, data: 8'h00};
    // write bit is the lsb, always 0 here
    localparam i2c_bus_pkg::i2c_cmd_t cmd_addr =
        '{op: i2c_bus_pkg::op_byte, data: {slave_addr, 1'b0}};
    localparam logic [2:0] last_cnt = 3'(ball_link_pkg::frame_bytes);

    ball_link_pkg::link_phase_t phase;
    ball_link_pkg::link_phase_t phase_next;
    ball_link_pkg::ball_frame_t frame_q;
    i2c_bus_pkg::i2c_cmd_t      cmd_next;
    logic [2:0]                 byte_cnt;
    logic [2:0]                 byte_cnt_next;
    logic                       issue;
    logic                       nack_set;
    logic                       cancel_pending;
    logic                       cancel;

    function automatic logic [7:0] frame_byte(ball_link_pkg::ball_frame_t f, logic [1:0] idx);
        case (idx)
            2'd0:    frame_byte = f.byte0;
            2'd1:    frame_byte = f.byte1;
            2'd2:    frame_byte = f.byte2;
            default: frame_byte = f.byte3;
        endcase
    endfunction

    assign frame_taken = (phase == ball_link_pkg::idle) && frame_valid;
    assign busy        = (phase != ball_link_pkg::idle) || frame_taken;
    assign cancel      = cancel_pending || ball_moving_left;
    assign phase_led   = 8'd1 << phase;

    // byte_cnt counts data bytes already handed to the engine
    always_comb begin
        phase_next    = phase;
        byte_cnt_next = byte_cnt;
        cmd_next      = cmd_stop;
        issue         = 1'b0;
        nack_set      = 1'b0;
        case (phase)
            ball_link_pkg::idle: begin
                if (frame_valid) begin
                    phase_next    = ball_link_pkg::start;
                    byte_cnt_next = 3'd0;
                    cmd_next      = cmd_start;
                    issue         = 1'b1;
                end
            end
            ball_link_pkg::start: begin
                if (status.done) begin
                    issue = 1'b1;
                    if (cancel) begin
                        phase_next = ball_link_pkg::stop;
                    end else begin
                        phase_next = ball_link_pkg::address;
                        cmd_next   = cmd_addr;
                    end
                end
            end
            ball_link_pkg::address, ball_link_pkg::data: begin
                if (status.done) begin
                    issue = 1'b1;
                    if (!status.ack) begin
                        nack_set   = 1'b1;
                        phase_next = ball_link_pkg::stop;
                    end else if (cancel || byte_cnt == last_cnt) begin
                        phase_next = ball_link_pkg::stop;
                    end else begin
                        phase_next    = ball_link_pkg::data;
                        cmd_next.op   = i2c_bus_pkg::op_byte;
                        cmd_next.data = frame_byte(frame_q, byte_cnt[1:0]);
                        byte_cnt_next = byte_cnt + 3'd1;
                    end
                end
            end
            ball_link_pkg::stop: begin
                if (status.done) begin
                    phase_next = ball_link_pkg::done;
                end
            end
            default: phase_next = ball_link_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase          <= ball_link_pkg::idle;
            byte_cnt       <= 3'd0;
            cmd_valid      <= 1'b0;
            nack           <= 1'b0;
            cancel_pending <= 1'b0;
        end else begin
            phase    <= phase_next;
            byte_cnt <= byte_cnt_next;
            if (issue) begin
                cmd_valid <= 1'b1;
            end else if (status.ready) begin
                cmd_valid <= 1'b0;
            end
            if (frame_taken) begin
                nack           <= 1'b0;
                cancel_pending <= 1'b0;
            end else begin
                if (nack_set) begin
                    nack <= 1'b1;
                end
                // acted on at the next done
                if (ball_moving_left && phase != ball_link_pkg::idle) begin
                    cancel_pending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_taken) begin
            frame_q <= frame;
        end
        if (issue) begin
            cmd <= cmd_next;
        end
    end

    engine_ready_on_issue: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !status.ready |=> !cmd_valid);

    phase_led_one_hot: assert property (@(posedge clk) disable iff (reset)
        $onehot(phase_led));

endmodule

/* source/ball_frame_capture.sv */
`timescale 1ns/1ps

module ball_frame_capture (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ball_send_trigger,
    input  ball_link_pkg::ball_snapshot_t ball,
    input  logic                          busy,
    input  logic                          frame_taken,
    output ball_link_pkg::ball_frame_t    frame,
    output logic                          frame_valid
);

    ball_link_pkg::ball_snapshot_t snap;
    logic                          capture;

    // triggers under back-pressure are dropped
    assign capture = ball_send_trigger && !frame_valid && !busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_valid <= 1'b0;
        end else if (capture) begin
            frame_valid <= 1'b1;
        end else if (frame_taken) begin
            frame_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            snap <= ball;
        end
    end

    // top two bits of y sit left aligned in the first byte
    always_comb begin
        frame.byte0 = {snap.y[9:8], 6'b00_0000};
        frame.byte1 = snap.y[7:0];
        frame.byte2 = snap.vy;
        frame.byte3 = ball_link_pkg::frame_marker;
    end

    frame_held: assert property (@(posedge clk) disable iff (reset)
        frame_valid && !frame_taken |=> $stable(frame));

endmodule

/* source/i2c_bus_pkg.sv */
package i2c_bus_pkg;

    typedef enum logic [1:0] {
        op_start,
        op_byte,
        op_stop
    } i2c_op_t;

    // data only matters for op_byte
    typedef struct packed {
        i2c_op_t    op;
        logic [7:0] data;
    } i2c_cmd_t;

    // ack is valid in the done cycle of a byte, 1 when the slave pulled sda low
    typedef struct packed {
        logic ready;
        logic done;
        logic ack;
    } i2c_status_t;

endpackage

/* source/ball_link_pkg.sv */
package ball_link_pkg;

    // ball state as seen by the game logic
    typedef struct packed {
        logic [9:0] y;
        logic [7:0] vy;
    } ball_snapshot_t;

    // byte0 goes on the wire first
    typedef struct packed {
        logic [7:0] byte0;
        logic [7:0] byte1;
        logic [7:0] byte2;
        logic [7:0] byte3;
    } ball_frame_t;

    localparam int frame_bytes = 4;

    localparam logic [7:0] frame_marker = 8'h01;

    // value is the bit position on the status leds
    typedef enum logic [2:0] {
        idle,
        start,
        address,
        data,
        stop,
        done
    } link_phase_t;

endpackage
